// ==== src/hash_accel_pkg.sv ====
// Shared widths, memory port and register structs, state enums, SHA-512 constant tables
`default_nettype none

package hash_accel_pkg;

  localparam int CL_ADDR_W = 42;
  localparam int CL_DATA_W = 512;

  typedef logic [CL_ADDR_W-1:0] t_cl_addr;
  typedef logic [CL_DATA_W-1:0] t_cl_data;

  // Read request, len2 asks for two consecutive lines
  typedef struct packed {
    logic     valid;
    t_cl_addr addr;
    logic     len2;
  } t_rd_req;

  typedef struct packed {
    logic     valid;
    logic     cl_num;   // 0 for the first line of a pair
    t_cl_data data;
  } t_rd_rsp;

  typedef struct packed {
    logic     valid;
    t_cl_addr addr;
    t_cl_data data;
  } t_wr_req;

  // Buffer sizes are counted in lines
  typedef struct packed {
    t_cl_addr in_addr;
    t_cl_addr in_size;
    t_cl_addr out_addr;
    t_cl_addr out_size;
    t_cl_addr dsm_addr;
  } t_hc_regs;

  typedef enum logic [2:0] {
    CSR_IN_ADDR  = 3'd0,
    CSR_IN_SIZE  = 3'd1,
    CSR_OUT_ADDR = 3'd2,
    CSR_OUT_SIZE = 3'd3,
    CSR_DSM_ADDR = 3'd4,
    CSR_CONTROL  = 3'd5
  } t_csr_addr;

  localparam logic [31:0] HC_CONTROL_START = 32'h0000_0001;

  typedef enum logic [2:0] {
    RD_IDLE,
    RD_FETCH,
    RD_WAIT_0,
    RD_WAIT_1,
    RD_FINISH
  } t_rd_state;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_FINISH
  } t_wr_state;

  typedef enum logic [1:0] {
    CORE_IDLE,
    CORE_LOAD,
    CORE_ROUND,
    CORE_UPDATE
  } t_core_state;

  localparam logic [63:0] SHA512_K [80] = '{
    64'h428a2f98d728ae22, 64'h7137449123ef65cd, 64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
    64'h3956c25bf348b538, 64'h59f111f1b605d019, 64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
    64'hd807aa98a3030242, 64'h12835b0145706fbe, 64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
    64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1, 64'h9bdc06a725c71235, 64'hc19bf174cf692694,
    64'he49b69c19ef14ad2, 64'hefbe4786384f25e3, 64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
    64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483, 64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
    64'h983e5152ee66dfab, 64'ha831c66d2db43210, 64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
    64'hc6e00bf33da88fc2, 64'hd5a79147930aa725, 64'h06ca6351e003826f, 64'h142929670a0e6e70,
    64'h27b70a8546d22ffc, 64'h2e1b21385c26c926, 64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
    64'h650a73548baf63de, 64'h766a0abb3c77b2a8, 64'h81c2c92e47edaee6, 64'h92722c851482353b,
    64'ha2bfe8a14cf10364, 64'ha81a664bbc423001, 64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
    64'hd192e819d6ef5218, 64'hd69906245565a910, 64'hf40e35855771202a, 64'h106aa07032bbd1b8,
    64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53, 64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
    64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb, 64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
    64'h748f82ee5defb2fc, 64'h78a5636f43172f60, 64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
    64'h90befffa23631e28, 64'ha4506cebde82bde9, 64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
    64'hca273eceea26619c, 64'hd186b8c721c0c207, 64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
    64'h06f067aa72176fba, 64'h0a637dc5a2c898a6, 64'h113f9804bef90dae, 64'h1b710b35131c471b,
    64'h28db77f523047d84, 64'h32caab7b40c72493, 64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
    64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a, 64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
  };

  // H0 word 0 first, it sits in the top 64 bits of a digest line
  localparam logic [63:0] SHA512_H0 [8] = '{
    64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b, 64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1, 64'h9b05688c2b3e6c1f, 64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
  };

endpackage : hash_accel_pkg

`default_nettype wire

// ==== src/hash_csr.sv ====
// Host register file and start pulse decode
`timescale 1ns/1ns
`default_nettype none

module hash_csr (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      host_wr,
  input  hash_accel_pkg::t_csr_addr host_addr,
  input  logic [63:0]               host_data,
  output hash_accel_pkg::t_hc_regs  regs,
  output logic                      start
);

  localparam int AW = hash_accel_pkg::CL_ADDR_W;

  logic start_wr;

  // Only an explicit write of the start code counts
  assign start_wr = host_wr && (host_addr == hash_accel_pkg::CSR_CONTROL) &&
                    (host_data == 64'(hash_accel_pkg::HC_CONTROL_START));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs  <= '0;
      start <= 1'b0;
    end else begin
      start <= start_wr;   // One cycle per write
      if (host_wr) begin
        case (host_addr)
          hash_accel_pkg::CSR_IN_ADDR:  regs.in_addr  <= host_data[AW-1:0];
          hash_accel_pkg::CSR_IN_SIZE:  regs.in_size  <= host_data[AW-1:0];
          hash_accel_pkg::CSR_OUT_ADDR: regs.out_addr <= host_data[AW-1:0];
          hash_accel_pkg::CSR_OUT_SIZE: regs.out_size <= host_data[AW-1:0];
          hash_accel_pkg::CSR_DSM_ADDR: regs.dsm_addr <= host_data[AW-1:0];
          default: begin
          end
        endcase
      end
    end
  end

endmodule : hash_csr

`default_nettype wire

// ==== src/sha512_requestor.sv ====
// Read and write FSMs, four-line reorder buffer, block feed to the core, digest writes
`timescale 1ns/1ns
`default_nettype none

module sha512_requestor (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  input  hash_accel_pkg::t_hc_regs regs,
  input  hash_accel_pkg::t_rd_rsp  rd_rsp,
  input  logic                     rd_alm_full,
  input  logic                     wr_alm_full,
  input  logic                     core_ready,
  input  logic [511:0]             digest,
  input  logic                     digest_valid,
  output hash_accel_pkg::t_rd_req  rd_req,
  output hash_accel_pkg::t_wr_req  wr_req,
  output logic [511:0]             block,
  output logic                     block_valid
);

  hash_accel_pkg::t_rd_state rd_state;
  hash_accel_pkg::t_wr_state wr_state;
  hash_accel_pkg::t_cl_addr  rd_off;    // Lines requested so far
  hash_accel_pkg::t_cl_addr  wr_cnt;    // Digest lines written
  hash_accel_pkg::t_cl_data  slot_data [4];
  hash_accel_pkg::t_cl_data  wr_digest;

  logic [3:0] slot_full;
  logic [1:0] drain_ptr;
  logic [1:0] rsp_cnt;
  logic [1:0] rsp_slot;
  logic       pair_free;
  logic       dv_prev;
  logic       dv_rise;
  logic       wr_pend;

  // Slot index is pair parity then line number
  assign rsp_slot  = {rsp_cnt[1], rd_rsp.cl_num};
  assign pair_free = !slot_full[{rd_off[1], 1'b0}] && !slot_full[{rd_off[1], 1'b1}];
  assign dv_rise   = digest_valid && !dv_prev;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_state <= hash_accel_pkg::RD_IDLE;
      rd_off   <= '0;
      rd_req   <= '0;
    end else begin
      rd_req.valid <= 1'b0;
      case (rd_state)
        hash_accel_pkg::RD_IDLE, hash_accel_pkg::RD_FINISH: begin
          if (start) begin
            rd_off   <= '0;
            rd_state <= hash_accel_pkg::RD_FETCH;
          end
        end
        hash_accel_pkg::RD_FETCH: begin
          if (!rd_alm_full && pair_free) begin
            rd_req.valid <= 1'b1;
            rd_req.addr  <= regs.in_addr + rd_off;
            rd_req.len2  <= 1'b1;
            rd_off       <= rd_off + hash_accel_pkg::t_cl_addr'(2);
            rd_state     <= hash_accel_pkg::RD_WAIT_0;
          end
        end
        hash_accel_pkg::RD_WAIT_0: begin
          if (rd_rsp.valid) rd_state <= hash_accel_pkg::RD_WAIT_1;
        end
        hash_accel_pkg::RD_WAIT_1: begin
          if (rd_rsp.valid) begin
            rd_state <= (rd_off == regs.in_size) ? hash_accel_pkg::RD_FINISH
                                                 : hash_accel_pkg::RD_FETCH;
          end
        end
        default: rd_state <= hash_accel_pkg::RD_IDLE;
      endcase
    end
  end

  // Responses land in any order, drain strictly by position
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 4; i++) begin
        slot_data[i] <= '0;
      end
      slot_full   <= '0;
      drain_ptr   <= '0;
      rsp_cnt     <= '0;
      block       <= '0;
      block_valid <= 1'b0;
    end else if (start) begin
      slot_full   <= '0;
      drain_ptr   <= '0;
      rsp_cnt     <= '0;
      block_valid <= 1'b0;
    end else begin
      block_valid <= 1'b0;
      if (slot_full[drain_ptr] && core_ready) begin
        block                <= slot_data[drain_ptr];
        block_valid          <= 1'b1;
        slot_full[drain_ptr] <= 1'b0;
        drain_ptr            <= drain_ptr + 2'd1;
      end
      if (rd_rsp.valid) begin
        slot_data[rsp_slot] <= rd_rsp.data;
        slot_full[rsp_slot] <= 1'b1;
        rsp_cnt             <= rsp_cnt + 2'd1;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_state  <= hash_accel_pkg::WR_IDLE;
      wr_cnt    <= '0;
      wr_digest <= '0;
      wr_req    <= '0;
      dv_prev   <= 1'b0;
      wr_pend   <= 1'b0;
    end else begin
      dv_prev      <= digest_valid;
      wr_req.valid <= 1'b0;
      if (start) begin
        wr_cnt  <= '0;
        wr_pend <= 1'b0;
      end
      if (dv_rise && wr_state != hash_accel_pkg::WR_IDLE) wr_pend <= 1'b1;  // Held off by alm_full
      case (wr_state)
        hash_accel_pkg::WR_IDLE: begin
          if (dv_rise || wr_pend) begin
            wr_digest <= digest;
            wr_pend   <= 1'b0;
            wr_state  <= hash_accel_pkg::WR_DATA;
          end
        end
        hash_accel_pkg::WR_DATA: begin
          if (!wr_alm_full) begin
            wr_req.valid <= 1'b1;
            wr_req.addr  <= regs.out_addr + wr_cnt;
            wr_req.data  <= wr_digest;
            wr_cnt       <= wr_cnt + hash_accel_pkg::t_cl_addr'(1);
            if ((wr_cnt + hash_accel_pkg::t_cl_addr'(1)) == regs.out_size) begin
              wr_state <= hash_accel_pkg::WR_FINISH;
            end else begin
              wr_state <= hash_accel_pkg::WR_IDLE;
            end
          end
        end
        hash_accel_pkg::WR_FINISH: begin
          if (!wr_alm_full) begin
            wr_req.valid <= 1'b1;
            wr_req.addr  <= regs.dsm_addr;
            wr_req.data  <= hash_accel_pkg::t_cl_data'(1);   // Job done
            wr_state     <= hash_accel_pkg::WR_IDLE;
          end
        end
        default: wr_state <= hash_accel_pkg::WR_IDLE;
      endcase
    end
  end

endmodule : sha512_requestor

`default_nettype wire

// ==== src/sha512_core.sv ====
// SHA-512 compression core with two-half block load and chained digest
`timescale 1ns/1ns
`default_nettype none

module sha512_core (
  input  logic         clk,
  input  logic         reset,
  input  logic         start,
  input  logic [511:0] block,
  input  logic         block_valid,
  output logic         core_ready,
  output logic [511:0] digest,
  output logic         digest_valid
);

  hash_accel_pkg::t_core_state state;

  logic              half;    // Second half expected next
  logic [6:0]        round;
  logic [0:15][63:0] w;       // Schedule window, w[0] is the current word
  logic [0:7][63:0]  hs;      // Chaining state, hs[0] in the top bits
  logic [63:0]       a, b, c, d, e, f, g, h;
  logic [63:0]       t1, t2, w_next;

  function automatic logic [63:0] ror(input logic [63:0] x, input int n);
    return (x >> n) | (x << (64 - n));
  endfunction

  function automatic logic [63:0] big_sigma0(input logic [63:0] x);
    return ror(x, 28) ^ ror(x, 34) ^ ror(x, 39);
  endfunction

  function automatic logic [63:0] big_sigma1(input logic [63:0] x);
    return ror(x, 14) ^ ror(x, 18) ^ ror(x, 41);
  endfunction

  function automatic logic [63:0] small_sigma0(input logic [63:0] x);
    return ror(x, 1) ^ ror(x, 8) ^ (x >> 7);
  endfunction

  function automatic logic [63:0] small_sigma1(input logic [63:0] x);
    return ror(x, 19) ^ ror(x, 61) ^ (x >> 6);
  endfunction

  always_comb begin
    t1 = h + big_sigma1(e) + ((e & f) ^ (~e & g)) +
         hash_accel_pkg::SHA512_K[round] + w[0];
    t2 = big_sigma0(a) + ((a & b) ^ (a & c) ^ (b & c));
    w_next = small_sigma1(w[14]) + w[9] + small_sigma0(w[1]) + w[0];
  end

  // Drops in the same cycle the second half is on block
  assign core_ready = (state == hash_accel_pkg::CORE_IDLE) && !(half && block_valid);
  assign digest     = hs;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state        <= hash_accel_pkg::CORE_IDLE;
      half         <= 1'b0;
      round        <= '0;
      digest_valid <= 1'b0;
    end else if (start) begin
      state <= hash_accel_pkg::CORE_IDLE;
      half  <= 1'b0;
    end else begin
      case (state)
        hash_accel_pkg::CORE_IDLE: begin
          if (block_valid && !half) begin
            half         <= 1'b1;
            digest_valid <= 1'b0;
          end else if (block_valid) begin
            half  <= 1'b0;
            state <= hash_accel_pkg::CORE_LOAD;
          end
        end
        hash_accel_pkg::CORE_LOAD: begin
          round <= '0;
          state <= hash_accel_pkg::CORE_ROUND;
        end
        hash_accel_pkg::CORE_ROUND: begin
          if (round == 7'd79) state <= hash_accel_pkg::CORE_UPDATE;
          else round <= round + 7'd1;
        end
        hash_accel_pkg::CORE_UPDATE: begin
          digest_valid <= 1'b1;
          state        <= hash_accel_pkg::CORE_IDLE;
        end
        default: state <= hash_accel_pkg::CORE_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      for (int i = 0; i < 8; i++) begin
        hs[i] <= hash_accel_pkg::SHA512_H0[i];
      end
    end else begin
      case (state)
        hash_accel_pkg::CORE_IDLE: begin
          if (block_valid) begin
            for (int i = 0; i < 8; i++) begin
              w[{half, 3'(i)}] <= block[511 - 64*i -: 64];   // Big-endian words
            end
          end
        end
        hash_accel_pkg::CORE_LOAD: begin
          {a, b, c, d, e, f, g, h} <= hs;
        end
        hash_accel_pkg::CORE_ROUND: begin
          h <= g;
          g <= f;
          f <= e;
          e <= d + t1;
          d <= c;
          c <= b;
          b <= a;
          a <= t1 + t2;
          for (int i = 0; i < 15; i++) begin
            w[i] <= w[i+1];
          end
          w[15] <= w_next;
        end
        hash_accel_pkg::CORE_UPDATE: begin
          hs[0] <= hs[0] + a;
          hs[1] <= hs[1] + b;
          hs[2] <= hs[2] + c;
          hs[3] <= hs[3] + d;
          hs[4] <= hs[4] + e;
          hs[5] <= hs[5] + f;
          hs[6] <= hs[6] + g;
          hs[7] <= hs[7] + h;
        end
        default: begin
        end
      endcase
    end
  end

endmodule : sha512_core

`default_nettype wire

// ==== src/sha512_accel.sv ====
// Accelerator top level joining register file, requestor and SHA-512 core
`timescale 1ns/1ns
`default_nettype none

module sha512_accel (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      host_wr,
  input  hash_accel_pkg::t_csr_addr host_addr,
  input  logic [63:0]               host_data,
  output hash_accel_pkg::t_rd_req   rd_req,
  output hash_accel_pkg::t_wr_req   wr_req,
  input  hash_accel_pkg::t_rd_rsp   rd_rsp,
  input  logic                      rd_alm_full,
  input  logic                      wr_alm_full
);

  hash_accel_pkg::t_hc_regs regs;
  logic                     start;
  logic [511:0]             block;
  logic                     block_valid;
  logic                     core_ready;
  logic [511:0]             digest;
  logic                     digest_valid;

  hash_csr csr (
    .clk       (clk),
    .reset     (reset),
    .host_wr   (host_wr),
    .host_addr (host_addr),
    .host_data (host_data),
    .regs      (regs),
    .start     (start)
  );

  sha512_requestor requestor (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .regs         (regs),
    .rd_rsp       (rd_rsp),
    .rd_alm_full  (rd_alm_full),
    .wr_alm_full  (wr_alm_full),
    .core_ready   (core_ready),
    .digest       (digest),
    .digest_valid (digest_valid),
    .rd_req       (rd_req),
    .wr_req       (wr_req),
    .block        (block),
    .block_valid  (block_valid)
  );

  sha512_core core (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .block        (block),
    .block_valid  (block_valid),
    .core_ready   (core_ready),
    .digest       (digest),
    .digest_valid (digest_valid)
  );

endmodule : sha512_accel

`default_nettype wire

// ==== bench/tb_clock.sv ====
// Free-running testbench clock
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD / 2) clk = ~clk;

endmodule : tb_clock

`default_nettype wire

// ==== bench/sha512_accel_tb.sv ====
// SHA-512 accelerator testbench with memory model, LCG back-pressure, reference model, watchdog
`timescale 1ns/1ns
`default_nettype none

module sha512_accel_tb;

  localparam int  TOTAL_BLOCKS = 13;  // All jobs together
  localparam int  MAX_DELAY    = 9;
  localparam longint LIMIT_CYCLES = TOTAL_BLOCKS * 200 + TOTAL_BLOCKS * 2 * MAX_DELAY + 400;

  logic                      clk;
  logic                      reset;
  logic                      host_wr;
  hash_accel_pkg::t_csr_addr host_addr;
  logic [63:0]               host_data;
  hash_accel_pkg::t_rd_req   rd_req;
  hash_accel_pkg::t_wr_req   wr_req;
  hash_accel_pkg::t_rd_rsp   rd_rsp;
  logic                      rd_alm_full;
  logic                      wr_alm_full;

  logic [31:0]   lcg_state = 32'h4c97_2e36;
  logic [511:0]  mem [logic [41:0]];
  logic [41:0]   pend_addr [$];
  logic          pend_cl [$];
  longint        pend_due [$];
  logic [41:0]   exp_addr [$];
  logic [511:0]  exp_data [$];
  string         exp_name [$];
  logic [1023:0] msg [4];
  longint        cycle = 0;
  int            rd_count = 0;
  logic          bp_on = 1'b0;
  logic          rd_af_d = 1'b0;
  logic          wr_af_d = 1'b0;

  tb_clock #(.PERIOD(100)) clock_gen (.clk(clk));

  sha512_accel UUT (
    .clk         (clk),
    .reset       (reset),
    .host_wr     (host_wr),
    .host_addr   (host_addr),
    .host_data   (host_data),
    .rd_req      (rd_req),
    .wr_req      (wr_req),
    .rd_rsp      (rd_rsp),
    .rd_alm_full (rd_alm_full),
    .wr_alm_full (wr_alm_full)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [63:0] rotr(input logic [63:0] x, input int n);
    return (x >> n) | (x << (64 - n));
  endfunction

  function automatic logic [511:0] initial_state();
    logic [511:0] st;
    for (int i = 0; i < 8; i++) begin
      st[511 - 64*i -: 64] = hash_accel_pkg::SHA512_H0[i];
    end
    return st;
  endfunction

  // One FIPS 180-4 compression of a 1024-bit block into a chaining state
  function automatic logic [511:0] ref_compress(input logic [511:0] st, input logic [1023:0] blk);
    logic [63:0]  w [80];
    logic [63:0]  v [8];
    logic [63:0]  t1;
    logic [63:0]  t2;
    logic [511:0] res;
    for (int i = 0; i < 16; i++) begin
      w[i] = blk[1023 - 64*i -: 64];
    end
    for (int i = 16; i < 80; i++) begin
      w[i] = (rotr(w[i-2], 19) ^ rotr(w[i-2], 61) ^ (w[i-2] >> 6)) + w[i-7] +
             (rotr(w[i-15], 1) ^ rotr(w[i-15], 8) ^ (w[i-15] >> 7)) + w[i-16];
    end
    for (int i = 0; i < 8; i++) begin
      v[i] = st[511 - 64*i -: 64];
    end
    for (int i = 0; i < 80; i++) begin
      t1 = v[7] + (rotr(v[4], 14) ^ rotr(v[4], 18) ^ rotr(v[4], 41)) +
           ((v[4] & v[5]) ^ (~v[4] & v[6])) + hash_accel_pkg::SHA512_K[i] + w[i];
      t2 = (rotr(v[0], 28) ^ rotr(v[0], 34) ^ rotr(v[0], 39)) +
           ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
      v[7] = v[6];
      v[6] = v[5];
      v[5] = v[4];
      v[4] = v[3] + t1;
      v[3] = v[2];
      v[2] = v[1];
      v[1] = v[0];
      v[0] = t1 + t2;
    end
    for (int i = 0; i < 8; i++) begin
      res[511 - 64*i -: 64] = st[511 - 64*i -: 64] + v[i];
    end
    return res;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [511:0] expected,
                             input logic [511:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      report_failure("value check failed");
    end
  endtask

  task automatic csr_write(input hash_accel_pkg::t_csr_addr addr, input logic [63:0] data);
    @(posedge clk);
    host_wr   <= 1'b1;
    host_addr <= addr;
    host_data <= data;
    @(posedge clk);
    host_wr   <= 1'b0;
  endtask

  // Loads blocks, queues expected lines, starts the job and waits for its status line
  task automatic run_job(input string name, input logic [41:0] in_addr,
                         input logic [41:0] out_addr, input logic [41:0] dsm_addr,
                         input int nblk);
    logic [511:0] st;
    st = initial_state();
    for (int b = 0; b < nblk; b++) begin
      mem[in_addr + 42'(2*b)]     = msg[b][1023:512];   // Lower line is the first half
      mem[in_addr + 42'(2*b + 1)] = msg[b][511:0];
      st = ref_compress(st, msg[b]);
      exp_addr.push_back(out_addr + 42'(b));
      exp_data.push_back(st);
      exp_name.push_back($sformatf("%s digest %0d", name, b));
    end
    exp_addr.push_back(dsm_addr);
    exp_data.push_back(512'd1);
    exp_name.push_back({name, " status"});
    csr_write(hash_accel_pkg::CSR_IN_ADDR, 64'(in_addr));
    csr_write(hash_accel_pkg::CSR_IN_SIZE, 64'(2*nblk));
    csr_write(hash_accel_pkg::CSR_OUT_ADDR, 64'(out_addr));
    csr_write(hash_accel_pkg::CSR_OUT_SIZE, 64'(nblk));
    csr_write(hash_accel_pkg::CSR_DSM_ADDR, 64'(dsm_addr));
    csr_write(hash_accel_pkg::CSR_CONTROL, 64'(hash_accel_pkg::HC_CONTROL_START));
    while (exp_addr.size() != 0) @(posedge clk);
  endtask

  // Memory model and write comparison
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (!reset) begin
      if (rd_req.valid && !rd_req.len2) report_failure("read request without the two-line flag");
      if (rd_req.valid && rd_af_d) report_failure("read request issued after rd_alm_full high");
      if (wr_req.valid && wr_af_d) report_failure("write request issued after wr_alm_full high");
      rd_af_d <= rd_alm_full;
      wr_af_d <= wr_alm_full;
      if (rd_req.valid) begin
        logic [31:0] r;
        longint      due;
        logic        swap;
        rd_count = rd_count + 1;
        r    = lcg_next();
        due  = cycle + 2 + longint'(r[11:8]) % MAX_DELAY;
        swap = bp_on && r[16];
        pend_addr.push_back(rd_req.addr + 42'(swap));
        pend_cl.push_back(swap);
        pend_due.push_back(due);
        pend_addr.push_back(rd_req.addr + 42'(!swap));
        pend_cl.push_back(!swap);
        pend_due.push_back(due + 1);
      end
      if (pend_due.size() != 0 && pend_due[0] <= cycle) begin
        rd_rsp.valid  <= 1'b1;
        rd_rsp.cl_num <= pend_cl.pop_front();
        rd_rsp.data   <= mem[pend_addr.pop_front()];
        void'(pend_due.pop_front());
      end else begin
        rd_rsp.valid <= 1'b0;
      end
      if (wr_req.valid) begin
        mem[wr_req.addr] = wr_req.data;
        if (exp_addr.size() == 0) begin
          report_failure("write request arrived when none was expected");
        end else begin
          check_equal({exp_name[0], " addr"}, 512'(exp_addr[0]), 512'(wr_req.addr));
          check_equal(exp_name[0], exp_data[0], wr_req.data);
          void'(exp_addr.pop_front());
          void'(exp_data.pop_front());
          void'(exp_name.pop_front());
        end
      end
      rd_alm_full <= bp_on && (lcg_next() % 4 == 0);
      wr_alm_full <= bp_on && (lcg_next() % 3 == 0);
    end
  end

  initial begin
    #(LIMIT_CYCLES * 100);
    $display("Watchdog expired before all tests finished");
    $display(">>> FAIL");
    $fatal(1);
  end

  initial begin
    logic [511:0] abc_digest;
    int           rd_before;
    reset       <= 1'b1;
    host_wr     <= 1'b0;
    host_addr   <= hash_accel_pkg::CSR_IN_ADDR;
    host_data   <= '0;
    rd_rsp      <= '0;
    rd_alm_full <= 1'b0;
    wr_alm_full <= 1'b0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // "abc" with standard padding and a 24-bit length
    msg[0] = '0;
    msg[0][1023:992] = 32'h6162_6380;
    msg[0][7:0] = 8'h18;
    abc_digest = {64'hddaf35a193617aba, 64'hcc417349ae204131, 64'h12e6fa4e89a97ea2,
                  64'h0a9eeee64b55d39a, 64'h2192992a274fc1a8, 64'h36ba3c23a3feebbd,
                  64'h454d4423643ce80e, 64'h2a9ac94fa54ca49f};
    check_equal("abc reference", abc_digest, ref_compress(initial_state(), msg[0]));
    run_job("abc", 42'h100, 42'h200, 42'h300, 1);

    for (int b = 0; b < 4; b++) begin
      for (int j = 0; j < 32; j++) begin
        msg[b][32*j +: 32] = lcg_next();
      end
    end
    run_job("four blocks", 42'h1000, 42'h2000, 42'h3000, 4);

    bp_on <= 1'b1;   // Random almost-full and response reordering
    run_job("four blocks back-pressure", 42'h1000, 42'h2100, 42'h3100, 4);

    run_job("back-to-back job a", 42'h4000, 42'h5000, 42'h6000, 2);
    msg[0] = msg[3];
    msg[1] = msg[2];
    run_job("back-to-back job b", 42'h7000, 42'h8000, 42'h9000, 2);
    bp_on <= 1'b0;

    rd_before = rd_count;
    csr_write(hash_accel_pkg::CSR_CONTROL, 64'h2);
    repeat (50) @(posedge clk);
    check_equal("bad control value", 512'(rd_before), 512'(rd_count));

    $display(">>> PASS");
    $finish;
  end

endmodule : sha512_accel_tb

`default_nettype wire

// ==== sha512_accel.f ====
src/hash_accel_pkg.sv
src/hash_csr.sv
src/sha512_requestor.sv
src/sha512_core.sv
src/sha512_accel.sv
bench/tb_clock.sv
bench/sha512_accel_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sha512_accel_tb
FILELIST  ?= sha512_accel.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
